// ==== rtl/l0TribePkg.sv ====
// Shared widths, counts, thresholds and types of the L0 trigger primitive path
// Imported by every RTL module of the core
`default_nettype none

package l0TribePkg;

   // ============================================================
   // Datapath geometry
   // ============================================================
   localparam int unsigned numChannels   = 5;    // One per detector port
   localparam int unsigned wideWidth     = 256;  // Host word
   localparam int unsigned primWidth     = 32;   // Primitive toward the link
   localparam int unsigned slicesPerWide = wideWidth / primWidth;

   // Store depth and refill threshold, scaled down from the board FIFO
   localparam int unsigned fifoDepth     = 16;
   localparam int unsigned lowWater      = 4;    // Board value was 128

   // ============================================================
   // Sequencer and burst code timing, scaled for simulation
   // ============================================================
   localparam int unsigned settleCycles  = 200;  // Board value 200000
   localparam int unsigned resetCycles   = 650;  // Board value 65000000
   localparam int unsigned markCycles    = 4;    // SOB/EOB code length

   // ============================================================
   // Types
   // ============================================================
   typedef logic [wideWidth-1:0]               wideWordT;
   typedef logic [primWidth-1:0]               primWordT;
   typedef logic [$clog2(numChannels)-1:0]     chanIdxT;
   typedef logic [numChannels-1:0]             chanMaskT;
   typedef logic [$clog2(fifoDepth+1)-1:0]     fillCountT;  // 0 to fifoDepth
   typedef logic [$clog2(fifoDepth)-1:0]       fifoPtrT;
   typedef logic [$clog2(slicesPerWide)-1:0]   sliceIdxT;

   // Software reset sequencer
   typedef enum logic [1:0] {
      resetInit,    // Load counter
      resetSettle,  // Wait settleCycles
      resetHold,    // Channel reset active
      resetRun      // Normal operation
   } resetStateT;

endpackage

`default_nettype wire

// ==== rtl/burstControl.sv ====
// Software reset sequencer, SOB/EOB code generator on ECRST/BCRST and LED drive
// Channels take chanRstN as their reset, burst gates their refill requests
`default_nettype none

module burstControl (
   input  wire logic       OSC_50_BANK6,
   input  wire logic       rstN,
   input  wire logic [3:0] ctrlSig,
   output logic            chanRstN,
   output logic            burst,
   output logic            ECRST,
   output logic            BCRST,
   output logic [7:0]      LED
);
   import l0TribePkg::*;

   resetStateT  seqState;
   int unsigned seqCount;
   int unsigned markCount;
   logic        burstDly;
   logic        riseEdge;
   logic        fallEdge;

   // ============================================================
   // Software reset sequencer
   // ============================================================
   always_ff @(posedge OSC_50_BANK6) begin
      if (!rstN) begin
         seqState <= resetInit;
         seqCount <= 0;
      end else begin
         case (seqState)
            resetInit: begin
               seqCount <= 0;
               seqState <= resetSettle;
            end
            resetSettle: begin
               if (seqCount == settleCycles - 1) begin
                  seqCount <= 0;
                  seqState <= resetHold;
               end else begin
                  seqCount <= seqCount + 1;
               end
            end
            resetHold: begin
               if (seqCount == resetCycles - 1) begin
                  seqCount <= 0;
                  seqState <= resetRun;
               end else begin
                  seqCount <= seqCount + 1;
               end
            end
            resetRun: begin
               if (ctrlSig[1]) seqState <= resetInit;  // Host asks for a new reset
            end
            default: seqState <= resetInit;
         endcase
      end
   end

   assign chanRstN = rstN && (seqState != resetHold);

   // ============================================================
   // Burst level and SOB/EOB codes
   // ============================================================
   assign riseEdge = burst && !burstDly;
   assign fallEdge = !burst && burstDly;

   always_ff @(posedge OSC_50_BANK6) begin
      if (!rstN) begin
         burst     <= 1'b0;
         burstDly  <= 1'b0;
         markCount <= 0;
         ECRST     <= 1'b0;
         BCRST     <= 1'b0;
      end else begin
         burst    <= ctrlSig[0];
         burstDly <= burst;
         if (riseEdge || fallEdge) begin
            // SOB is 1/1, EOB is 1/0
            markCount <= markCycles - 1;
            ECRST     <= 1'b1;
            BCRST     <= riseEdge;
         end else if (markCount != 0) begin
            markCount <= markCount - 1;
         end else begin
            ECRST <= 1'b0;
            BCRST <= 1'b0;
         end
      end
   end

   // LEDs are lit low
   always_ff @(posedge OSC_50_BANK6) begin
      if (!rstN) begin
         LED <= 8'hff;
      end else begin
         LED[3:0] <= ~ctrlSig;
         LED[4]   <= ~(seqState == resetRun);
         LED[5]   <= ~ECRST;
         LED[7:6] <= 2'b11;  // Unused, dark
      end
   end

   // A code never outlasts its nominal length
   assert property (@(posedge OSC_50_BANK6) disable iff (!rstN)
      ECRST [*markCycles] |=> !ECRST)
      else $error("ECRST held longer than markCycles");

endmodule

`default_nettype wire

// ==== rtl/primitiveChannel.sv ====
// One primitive channel: stores host wide words and reads them out as primitives,
// least significant slice first, with a registered refill request during a burst
`default_nettype none

module primitiveChannel (
   input  wire logic                 OSC_50_BANK6,
   input  wire logic                 chanRstN,
   input  wire logic                 burst,
   input  wire logic                 wrEn,
   input  wire l0TribePkg::wideWordT wrData,
   input  wire logic                 rdReq,
   output l0TribePkg::primWordT      rdWord,
   output logic                      empty,
   output logic                      wrFull,
   output logic                      refillReq
);
   import l0TribePkg::*;

   wideWordT  mem [fifoDepth];
   fifoPtrT   wrPtr;
   fifoPtrT   rdPtr;
   fillCountT fillCount;
   fillCountT fillNext;
   sliceIdxT  sliceIdx;
   logic      retire;

   // ============================================================
   // Occupancy
   // ============================================================
   // Last slice read retires the wide word
   assign retire   = rdReq && (sliceIdx == sliceIdxT'(slicesPerWide - 1));
   assign fillNext = fillCount + fillCountT'(wrEn) - fillCountT'(retire);

   assign empty  = (fillCount == '0);
   assign wrFull = (fillCount == fillCountT'(fifoDepth));

   always_ff @(posedge OSC_50_BANK6) begin
      if (!chanRstN) begin
         fillCount <= '0;
         refillReq <= 1'b0;
      end else begin
         fillCount <= fillNext;
         // Taken from the next count so it moves with wrFull
         refillReq <= burst && (fillNext < fillCountT'(lowWater));
      end
   end

   // ============================================================
   // Write side
   // ============================================================
   always_ff @(posedge OSC_50_BANK6) begin
      if (wrEn) mem[wrPtr] <= wrData;
   end

   always_ff @(posedge OSC_50_BANK6) begin
      if (!chanRstN) begin
         wrPtr <= '0;
      end else if (wrEn) begin
         wrPtr <= wrPtr + 1'b1;  // Wraps at fifoDepth
      end
   end

   // ============================================================
   // Read side
   // ============================================================
   always_ff @(posedge OSC_50_BANK6) begin
      if (rdReq) rdWord <= mem[rdPtr][sliceIdx*primWidth +: primWidth];
   end

   always_ff @(posedge OSC_50_BANK6) begin
      if (!chanRstN) begin
         rdPtr    <= '0;
         sliceIdx <= '0;
      end else if (rdReq) begin
         if (retire) begin
            sliceIdx <= '0;
            rdPtr    <= rdPtr + 1'b1;
         end else begin
            sliceIdx <= sliceIdx + 1'b1;
         end
      end
   end

   // Host must respect wrFull, drain must respect empty
   assert property (@(posedge OSC_50_BANK6) disable iff (!chanRstN)
      wrEn |-> !wrFull)
      else $error("Write into full channel");

   assert property (@(posedge OSC_50_BANK6) disable iff (!chanRstN)
      rdReq |-> !empty)
      else $error("Read from empty channel");

endmodule

`default_nettype wire

// ==== rtl/primitiveDrain.sv ====
// Round-robin reader that moves primitives from the channels to the transmit port
// Grants one channel per cycle while txReady is high, word shows up one cycle later
`default_nettype none

module primitiveDrain (
   input  wire logic                 OSC_50_BANK6,
   input  wire logic                 rstN,
   input  wire l0TribePkg::chanMaskT empty,
   input  wire l0TribePkg::primWordT rdWord [l0TribePkg::numChannels],
   input  wire logic                 txReady,
   output l0TribePkg::chanMaskT      rdReq,
   output logic                      txValid,
   output l0TribePkg::primWordT      txWord,
   output l0TribePkg::chanIdxT       txPort
);
   import l0TribePkg::*;

   chanIdxT rrPtr;
   chanIdxT pick;
   logic    found;
   logic    grant;

   // ============================================================
   // Arbitration
   // ============================================================
   // First non-empty channel at or after the pointer
   always_comb begin
      int unsigned cand;
      found = 1'b0;
      pick  = '0;
      for (int unsigned k = 0; k < numChannels; k++) begin
         cand = rrPtr + k;
         if (cand >= numChannels) cand = cand - numChannels;
         if (!found && !empty[cand]) begin
            found = 1'b1;
            pick  = chanIdxT'(cand);
         end
      end
   end

   assign grant = txReady && found;

   always_comb begin
      rdReq = '0;
      if (grant) rdReq[pick] = 1'b1;
   end

   always_ff @(posedge OSC_50_BANK6) begin
      if (!rstN) begin
         rrPtr <= '0;
      end else if (grant) begin
         rrPtr <= (pick == chanIdxT'(numChannels - 1)) ? '0 : pick + 1'b1;
      end
   end

   // ============================================================
   // Transmit side
   // ============================================================
   always_ff @(posedge OSC_50_BANK6) begin
      if (!rstN) begin
         txValid <= 1'b0;
         txPort  <= '0;
      end else begin
         txValid <= grant;
         if (grant) txPort <= pick;
      end
   end

   assign txWord = rdWord[txPort];  // Channel registered it in the grant cycle

   // At most one read, only from a channel with data, and one whenever data waits
   assert property (@(posedge OSC_50_BANK6) disable iff (!rstN)
      $onehot0(rdReq) && ((rdReq & empty) == '0)
         && ((rdReq != '0) == (txReady && (empty != '1))))
      else $error("Drain grant does not match txReady and empty");

endmodule

`default_nettype wire

// ==== rtl/l0TribeTop.sv ====
// Top of the L0 trigger primitive path: burst controller, five channels and the drain
// Host writes wide words per channel, primitives leave on txWord/txPort
`default_nettype none

module l0TribeTop (
   input  wire logic                 OSC_50_BANK6,
   input  wire logic                 rstN,
   input  wire logic [3:0]           ctrlSig,
   input  wire l0TribePkg::wideWordT wrData,
   input  wire l0TribePkg::chanMaskT wrEn,
   input  wire logic                 txReady,
   output logic                      txValid,
   output l0TribePkg::primWordT      txWord,
   output l0TribePkg::chanIdxT       txPort,
   output l0TribePkg::chanMaskT      wrFull,
   output l0TribePkg::chanMaskT      refillReq,
   output logic                      ECRST,
   output logic                      BCRST,
   output logic [7:0]                LED
);
   import l0TribePkg::*;

   logic     chanRstN;
   logic     burst;
   chanMaskT rdReq;
   chanMaskT empty;
   primWordT rdWord [numChannels];

   // ============================================================
   // Reset sequencer, burst codes and LEDs
   // ============================================================
   burstControl burstControl_inst (
      .OSC_50_BANK6 (OSC_50_BANK6),
      .rstN         (rstN),
      .ctrlSig      (ctrlSig),
      .chanRstN     (chanRstN),
      .burst        (burst),
      .ECRST        (ECRST),
      .BCRST        (BCRST),
      .LED          (LED)
   );

   // ============================================================
   // Primitive channels, one per port
   // ============================================================
   for (genvar i = 0; i < numChannels; i++) begin : genChan
      primitiveChannel primitiveChannel_inst (
         .OSC_50_BANK6 (OSC_50_BANK6),
         .chanRstN     (chanRstN),
         .burst        (burst),
         .wrEn         (wrEn[i]),
         .wrData       (wrData),
         .rdReq        (rdReq[i]),
         .rdWord       (rdWord[i]),
         .empty        (empty[i]),
         .wrFull       (wrFull[i]),
         .refillReq    (refillReq[i])
      );
   end

   // Round-robin toward the transmit link
   primitiveDrain primitiveDrain_inst (
      .OSC_50_BANK6 (OSC_50_BANK6),
      .rstN         (rstN),
      .empty        (empty),
      .rdWord       (rdWord),
      .txReady      (txReady),
      .rdReq        (rdReq),
      .txValid      (txValid),
      .txWord       (txWord),
      .txPort       (txPort)
   );

endmodule

`default_nettype wire

// ==== tb/tbL0Tribe.sv ====
// Directed testbench for the L0 trigger primitive path
// Covers startup, slice order, round-robin, refill, burst codes and software reset
`default_nettype none

module tbL0Tribe;
   timeunit 1ns;
   timeprecision 100ps;

   import l0TribePkg::*;

   localparam int unsigned clkPeriod  = 8;
   localparam int unsigned testBudget = 400;  // Cycles per directed test
   localparam int unsigned numTests   = 6;
   // Startup and software reset each run the whole sequence
   localparam int unsigned watchdogCycles =
      2 * (settleCycles + resetCycles) + numTests * testBudget;

   logic       OSC_50_BANK6;
   logic       rstN;
   logic [3:0] ctrlSig;
   wideWordT   wrData;
   chanMaskT   wrEn;
   logic       txReady;
   logic       txValid;
   primWordT   txWord;
   chanIdxT    txPort;
   chanMaskT   wrFull;
   chanMaskT   refillReq;
   logic       ECRST;
   logic       BCRST;
   logic [7:0] LED;

   primWordT    expQ [numChannels][$];  // Expected primitives per channel
   int unsigned rrNext;                 // Channel the drain serves next when all are busy

   l0TribeTop l0TribeTop_inst (
      .OSC_50_BANK6 (OSC_50_BANK6),
      .rstN         (rstN),
      .ctrlSig      (ctrlSig),
      .wrData       (wrData),
      .wrEn         (wrEn),
      .txReady      (txReady),
      .txValid      (txValid),
      .txWord       (txWord),
      .txPort       (txPort),
      .wrFull       (wrFull),
      .refillReq    (refillReq),
      .ECRST        (ECRST),
      .BCRST        (BCRST),
      .LED          (LED)
   );

   initial begin
      OSC_50_BANK6 = 1'b0;
      forever #(clkPeriod / 2) OSC_50_BANK6 = ~OSC_50_BANK6;
   end

   initial begin
      #(watchdogCycles * clkPeriod);
      failRun("Watchdog expired before the tests finished");
   end

   // ============================================================
   // Helpers
   // ============================================================
   task automatic failRun(input string why);
      $display("%s", why);
      $display("Simulation failed");
      $fatal(1);
   endtask

   // Outputs settled, inputs may change
   task automatic tick();
      @(posedge OSC_50_BANK6);
      #1;
   endtask

   function automatic wideWordT randomWide();
      wideWordT word;
      for (int unsigned s = 0; s < slicesPerWide; s++) begin
         word[s*primWidth +: primWidth] = $urandom();
      end
      return word;
   endfunction

   // One write cycle, expected primitives queued least significant slice first
   task automatic writeWord(input chanMaskT mask, input wideWordT word);
      wrEn   = mask;
      wrData = word;
      for (int unsigned c = 0; c < numChannels; c++) begin
         if (mask[c]) begin
            for (int unsigned s = 0; s < slicesPerWide; s++) begin
               expQ[c].push_back(word[s*primWidth +: primWidth]);
            end
         end
      end
      tick();
      wrEn = '0;
   endtask

   // Current cycle first, then one cycle past the checked primitive
   task automatic expectPrim(input int unsigned port);
      int unsigned waited;
      primWordT    expWord;
      waited = 0;
      while (!txValid && waited < 50) begin
         tick();
         waited++;
      end
      assert (txValid)
         else failRun($sformatf("No primitive from channel %0d within 50 cycles", port));
      assert (txPort == chanIdxT'(port))
         else failRun($sformatf("error %0t ns: txPort %0d, expected %0d", $time, txPort, port));
      assert (expQ[port].size() != 0)
         else failRun($sformatf("Channel %0d sent a primitive that was never written", port));
      expWord = expQ[port].pop_front();
      assert (txWord == expWord)
         else failRun($sformatf("error %0t ns: txWord %h, expected %h", $time, txWord, expWord));
      rrNext = (port + 1) % numChannels;
      tick();
   endtask

   task automatic expectIdle(input int unsigned cycles);
      repeat (cycles) begin
         assert (!txValid)
            else failRun($sformatf("error %0t ns: unexpected primitive on port %0d", $time, txPort));
         tick();
      end
   endtask

   // LED 4 is high outside resetRun
   task automatic waitRunLed(input logic level, input int unsigned limit);
      int unsigned waited;
      waited = 0;
      while (LED[4] != level && waited < limit) begin
         tick();
         waited++;
      end
      assert (LED[4] == level)
         else failRun($sformatf("LED 4 did not reach %b within %0d cycles", level, limit));
   endtask

   // Cycle 1 registers burst, code follows for markCycles
   task automatic watchCode(input logic bcrstExp);
      logic       ecrstExp;
      logic       ecrstLast;
      logic [7:0] ledExp;
      for (int unsigned n = 1; n <= markCycles + 4; n++) begin
         tick();
         ecrstExp  = (n >= 2) && (n <= markCycles + 1);
         ecrstLast = (n >= 3) && (n <= markCycles + 2);  // LEDs lag by a cycle
         ledExp    = {2'b11, !ecrstLast, 1'b0, ~ctrlSig};
         assert (ECRST == ecrstExp && BCRST == (ecrstExp && bcrstExp))
            else failRun($sformatf("error %0t ns: ECRST %b BCRST %b in cycle %0d",
                                   $time, ECRST, BCRST, n));
         assert (LED == ledExp)
            else failRun($sformatf("error %0t ns: LED %b, expected %b in cycle %0d",
                                   $time, LED, ledExp, n));
      end
   endtask

   // ============================================================
   // Directed tests
   // ============================================================
   task automatic startupSequence();
      int unsigned total;
      total = settleCycles + resetCycles + 2;  // Init cycle plus registered LED
      for (int unsigned n = 1; n <= total; n++) begin
         tick();
         assert (!ECRST && !BCRST)
            else failRun($sformatf("error %0t ns: burst code during startup", $time));
         if (n < total) begin
            assert (LED[4])
               else failRun($sformatf("error %0t ns: LED 4 lit after %0d cycles", $time, n));
         end else begin
            assert (!LED[4])
               else failRun($sformatf("error %0t ns: LED 4 dark after %0d cycles", $time, n));
         end
      end
   endtask

   task automatic roundRobinDrain();
      txReady = 1'b0;
      for (int unsigned c = 0; c < numChannels; c++) begin
         writeWord(chanMaskT'(1 << c), randomWide());
      end
      expectIdle(10);
      txReady = 1'b1;
      for (int unsigned r = 0; r < slicesPerWide; r++) begin
         for (int unsigned k = 0; k < numChannels; k++) begin
            expectPrim(rrNext);
         end
      end
      expectIdle(10);
      txReady = 1'b0;
   endtask

   task automatic sliceOrder();
      txReady = 1'b1;
      writeWord(chanMaskT'(1 << 2), randomWide());
      writeWord(chanMaskT'(1 << 2), randomWide());
      repeat (2 * slicesPerWide) expectPrim(2);
      expectIdle(20);
      txReady = 1'b0;
   endtask

   task automatic refillAndFull();
      txReady = 1'b0;
      tick();
      assert (refillReq == '0)
         else failRun($sformatf("error %0t ns: refillReq %b outside a burst", $time, refillReq));
      ctrlSig[0] = 1'b1;
      repeat (3) tick();
      assert (refillReq == '1)
         else failRun($sformatf("error %0t ns: refillReq %b with empty stores", $time, refillReq));
      for (int unsigned i = 1; i <= fifoDepth; i++) begin
         writeWord(chanMaskT'(1), randomWide());
         assert (refillReq[0] == (i < lowWater) && refillReq[4:1] == '1)
            else failRun($sformatf("error %0t ns: refillReq %b after %0d writes",
                                   $time, refillReq, i));
         assert (wrFull[0] == (i == fifoDepth))
            else failRun($sformatf("error %0t ns: wrFull %b after %0d writes", $time, wrFull, i));
      end
      txReady = 1'b1;
      repeat (fifoDepth * slicesPerWide) expectPrim(0);
      expectIdle(10);
      txReady    = 1'b0;
      ctrlSig[0] = 1'b0;
      repeat (markCycles + 4) tick();
   endtask

   task automatic burstCodes();
      ctrlSig[0] = 1'b1;
      watchCode(1'b1);  // Start of burst
      ctrlSig[0] = 1'b0;
      watchCode(1'b0);  // End of burst
   endtask

   task automatic softReset();
      txReady    = 1'b0;
      ctrlSig[0] = 1'b1;
      repeat (markCycles + 4) tick();
      repeat (fifoDepth) writeWord('1, randomWide());
      assert (refillReq == '0)
         else failRun($sformatf("error %0t ns: refillReq %b with stored data", $time, refillReq));
      assert (wrFull == '1)
         else failRun($sformatf("error %0t ns: wrFull %b with full stores", $time, wrFull));
      ctrlSig[1] = 1'b1;
      tick();
      ctrlSig[1] = 1'b0;
      // Stores are cleared by the channel reset
      for (int unsigned c = 0; c < numChannels; c++) begin
         expQ[c].delete();
      end
      waitRunLed(1'b1, 10);
      waitRunLed(1'b0, settleCycles + resetCycles + 10);
      repeat (2) tick();
      assert (refillReq == '1)
         else failRun($sformatf("error %0t ns: refillReq %b after reset", $time, refillReq));
      assert (wrFull == '0)
         else failRun($sformatf("error %0t ns: wrFull %b after reset", $time, wrFull));
      txReady = 1'b1;
      expectIdle(20);
      txReady = 1'b0;
      ctrlSig = '0;
      repeat (markCycles + 4) tick();
   endtask

   // ============================================================
   // Test sequence
   // ============================================================
   initial begin
      void'($urandom(32'hebb5));
      rstN    = 1'b0;
      ctrlSig = '0;
      wrData  = '0;
      wrEn    = '0;
      txReady = 1'b0;
      rrNext  = 0;
      repeat (3) tick();
      rstN = 1'b1;

      startupSequence();
      roundRobinDrain();
      sliceOrder();
      refillAndFull();
      burstCodes();
      softReset();

      for (int unsigned c = 0; c < numChannels; c++) begin
         assert (expQ[c].size() == 0)
            else failRun($sformatf("Channel %0d still owes %0d primitives", c, expQ[c].size()));
      end
      $display("Simulation completed successfully");
      $finish;
   end

endmodule

`default_nettype wire

// ==== l0Tribe.f ====
rtl/l0TribePkg.sv
rtl/burstControl.sv
rtl/primitiveChannel.sv
rtl/primitiveDrain.sv
rtl/l0TribeTop.sv
tb/tbL0Tribe.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build the testbench with Verilator, run it and look for the pass message in the log
cd "$(dirname "$0")" || exit 1

logFile=sim.log
rm -f "$logFile"

verilator --binary --timing --assert -j 0 --top-module tbL0Tribe -f l0Tribe.f -o simL0Tribe \
   && ./obj_dir/simL0Tribe 2>&1 | tee "$logFile" \
   || { echo "Verilator build or run failed"; exit 1; }

grep -qx "Simulation completed successfully" "$logFile" \
   && echo "PASS" \
   || { echo "FAIL"; exit 1; }
